// ==== list.f ====
+incdir+hw
hw/chip_ctrl_pkg.sv
hw/apb_if.sv
hw/chip_ctrl_apb_demux.sv
hw/clk_ctrl_regs.sv
hw/pad_cfg_regs.sv
hw/pad_mux.sv
hw/chip_ctrl_top.sv
tests/tb_chip_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_chip_ctrl -o tb_chip_ctrl
./obj_dir/tb_chip_ctrl 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation done, see sim.log"

// ==== tests/tb_chip_ctrl.sv ====
`timescale 1ns/1ps
`include "chip_ctrl_cfg.svh"

module tb_chip_ctrl import chip_ctrl_pkg::*; ();

  localparam int PADS    = `CHIP_PAD_COUNT;
  localparam int TIMEOUT = 16;

  typedef logic [PADS-1:0] pad_vec_t;

  logic      clk;
  logic      rst_n;
  // APB master side
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  // Clock control
  logic      clk_byp_pad;
  logic [5:0] clk_outs;
  // Peripheral and pad side
  pad_vec_t  gpio_out;
  pad_vec_t  gpio_oe;
  pad_vec_t  gpio_in;
  logic      uart_tx;
  logic      uart_rx;
  logic [`CHIP_TIMER_CHANNELS-1:0] timer_ch;
  pad_vec_t  pad_out;
  pad_vec_t  pad_oe;
  pad_vec_t  pad_in;

  // Reference model state
  logic [5:0] m_clk;
  pad_func_e  m_func [PADS];

  string cur_test;
  int    errors;
  int    checks;
  int    xfers;
  int    late;

  chip_ctrl_top UUT (
    .soc_clk_i      ( clk         ),
    .rst_n_i        ( rst_n       ),
    .apb_psel_i     ( psel        ),
    .apb_penable_i  ( penable     ),
    .apb_pwrite_i   ( pwrite      ),
    .apb_paddr_i    ( paddr       ),
    .apb_pwdata_i   ( pwdata      ),
    .apb_prdata_o   ( prdata      ),
    .apb_pready_o   ( pready      ),
    .apb_pslverr_o  ( pslverr     ),
    .clk_byp_pad_i  ( clk_byp_pad ),
    .soc_clk_en_o   ( clk_outs[0] ),
    .soc_clk_byp_o  ( clk_outs[1] ),
    .per_clk_en_o   ( clk_outs[2] ),
    .per_clk_byp_o  ( clk_outs[3] ),
    .slow_clk_en_o  ( clk_outs[4] ),
    .slow_clk_byp_o ( clk_outs[5] ),
    .gpio_out_i     ( gpio_out    ),
    .gpio_oe_i      ( gpio_oe     ),
    .gpio_in_o      ( gpio_in     ),
    .uart_tx_i      ( uart_tx     ),
    .uart_rx_o      ( uart_rx     ),
    .timer_ch_i     ( timer_ch    ),
    .pad_out_o      ( pad_out     ),
    .pad_oe_o       ( pad_oe      ),
    .pad_in_i       ( pad_in      )
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0s/%0s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_test(input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("test %0s: ok", cur_test);
    end else begin
      $display("test %0s: %0d mismatches", cur_test, errors - errs_at_start);
    end
  endtask

  // Setup then access, sampled mid-cycle
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && waits < TIMEOUT) begin
      waits++;
      @(negedge clk);
    end
    if (!pready) begin
      $display("Transfer to 0x%0h never saw pready", addr);
      $display("TB FAILED");
      $finish;
    end else begin
      // Zero wait states expected on every target
      if (waits != 0) begin
        late++;
      end
      check_val("pready wait cycles", 0, waits);
      rdata = prdata;
      err   = pslverr;
      xfers++;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      @(negedge clk);
      // Response quiet while idle
      check_val("idle pready", 0, 32'(pready));
      check_val("idle pslverr", 0, 32'(pslverr));
    end
  endtask

  // Readback of every register against the model
  task automatic check_state();
    apb_data_t rd;
    logic      err;
    apb_xfer(1'b0, `CHIP_CLK_REGION_BASE, '0, rd, err);
    check_val("clk reg", 32'(m_clk), rd);
    check_val("clk pslverr", 0, 32'(err));
    for (int p = 0; p < PADS; p++) begin
      apb_xfer(1'b0, apb_addr_t'(`CHIP_PAD_REGION_BASE + 4 * p), '0, rd, err);
      check_val("pad func", 32'(m_func[p]), rd);
      check_val("pad pslverr", 0, 32'(err));
    end
  endtask

  task automatic expect_error(input apb_addr_t addr);
    apb_data_t rd;
    logic      err;
    apb_xfer(1'b1, addr, $urandom, rd, err);
    check_val("wr pslverr", 1, 32'(err));
    check_val("wr prdata", 0, rd);
    apb_xfer(1'b0, addr, '0, rd, err);
    check_val("rd pslverr", 1, 32'(err));
    check_val("rd prdata", 0, rd);
  endtask

  // Bypass outputs are the register bit or the pad
  task automatic check_clocks(input logic byp);
    @(posedge clk);
    clk_byp_pad <= byp;
    @(negedge clk);
    check_val("clock outputs", 32'(m_clk | (byp ? 6'b101010 : 6'b000000)), 32'(clk_outs));
  endtask

  // New random peripheral and pad inputs, then the routing model
  task automatic check_pads();
    pad_vec_t e_out;
    pad_vec_t e_oe;
    logic     e_rx;
    logic     rx_found;
    @(posedge clk);
    gpio_out <= pad_vec_t'($urandom);
    gpio_oe  <= pad_vec_t'($urandom);
    pad_in   <= pad_vec_t'($urandom);
    uart_tx  <= 1'($urandom);
    timer_ch <= 4'($urandom);
    @(negedge clk);
    e_rx     = 1'b1;
    rx_found = 1'b0;
    for (int p = 0; p < PADS; p++) begin
      case (m_func[p])
        PAD_FUNC_GPIO: begin
          e_out[p] = gpio_out[p];
          e_oe[p]  = gpio_oe[p];
        end
        PAD_FUNC_UART_TX: begin
          e_out[p] = uart_tx;
          e_oe[p]  = 1'b1;
        end
        PAD_FUNC_UART_RX: begin
          e_out[p] = 1'b0;
          e_oe[p]  = 1'b0;
          // First RX pad from index 0 up
          if (!rx_found) begin
            e_rx     = pad_in[p];
            rx_found = 1'b1;
          end
        end
        default: begin
          e_out[p] = timer_ch[p % `CHIP_TIMER_CHANNELS];
          e_oe[p]  = 1'b1;
        end
      endcase
    end
    check_val("pad_out", 32'(e_out), 32'(pad_out));
    check_val("pad_oe", 32'(e_oe), 32'(pad_oe));
    check_val("uart_rx", 32'(e_rx), 32'(uart_rx));
    check_val("gpio_in", 32'(pad_in), 32'(gpio_in));
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    apb_data_t rd;
    apb_data_t wdata;
    logic      err;
    int        errs0;
    int        p;
    errors = 0;
    checks = 0;
    xfers  = 0;
    late   = 0;
    void'($urandom(32'hfce8_d5ec));
    rst_n       <= 1'b0;
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    paddr       <= '0;
    pwdata      <= '0;
    clk_byp_pad <= 1'b0;
    gpio_out    <= '0;
    gpio_oe     <= '0;
    uart_tx     <= 1'b0;
    timer_ch    <= '0;
    pad_in      <= '0;
    // Reset state: enables on, bypasses off, all pads GPIO
    m_clk = 6'h15;
    for (int i = 0; i < PADS; i++) begin
      m_func[i] = PAD_FUNC_GPIO;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "reset";
    errs0    = errors;
    check_state();
    for (int i = 0; i < 4; i++) begin
      check_pads();
    end
    report_test(errs0);

    cur_test = "clock_regs";
    errs0    = errors;
    for (int i = 0; i < 16; i++) begin
      wdata = $urandom;
      apb_xfer(1'b1, `CHIP_CLK_REGION_BASE, wdata, rd, err);
      m_clk = wdata[5:0];
      check_val("clk wr pslverr", 0, 32'(err));
      apb_xfer(1'b0, `CHIP_CLK_REGION_BASE, '0, rd, err);
      check_val("clk readback", 32'(m_clk), rd);
      check_clocks(1'b0);
      check_clocks(1'b1);
    end
    report_test(errs0);

    cur_test = "pad_mux";
    errs0    = errors;
    for (int i = 0; i < 24; i++) begin
      p         = $urandom_range(PADS - 1, 0);
      m_func[p] = pad_func_e'(2'($urandom));
      apb_xfer(1'b1, apb_addr_t'(`CHIP_PAD_REGION_BASE + 4 * p), 32'(m_func[p]), rd, err);
      check_val("pad wr pslverr", 0, 32'(err));
      apb_xfer(1'b0, apb_addr_t'(`CHIP_PAD_REGION_BASE + 4 * p), '0, rd, err);
      check_val("pad readback", 32'(m_func[p]), rd);
      check_pads();
    end
    report_test(errs0);

    cur_test = "errors";
    errs0    = errors;
    for (int i = 0; i < 6; i++) begin
      // Above both regions, then bad clock offsets, then pads past the bank
      expect_error(apb_addr_t'(12'h200 + $urandom_range(12'hdff, 0)));
      expect_error(apb_addr_t'(`CHIP_CLK_REGION_BASE + $urandom_range(255, 1)));
      expect_error(apb_addr_t'(`CHIP_PAD_REGION_BASE + 4 * $urandom_range(63, PADS)));
    end
    check_state();
    check_pads();
    report_test(errs0);

    cur_test = "handshake";
    if (late == 0) begin
      $display("test %0s: ok, %0d transfers", cur_test, xfers);
    end else begin
      $display("test %0s: %0d of %0d transfers late", cur_test, late, xfers);
    end

    $display("checks %0d, errors %0d, transfers %0d", checks, errors, xfers);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/chip_ctrl_top.sv ====
`timescale 1ns/1ps
`include "chip_ctrl_cfg.svh"

module chip_ctrl_top import chip_ctrl_pkg::*; (
  input  logic                            soc_clk_i,
  input  logic                            rst_n_i,
  // APB slave port
  input  logic                            apb_psel_i,
  input  logic                            apb_penable_i,
  input  logic                            apb_pwrite_i,
  input  apb_addr_t                       apb_paddr_i,
  input  apb_data_t                       apb_pwdata_i,
  output apb_data_t                       apb_prdata_o,
  output logic                            apb_pready_o,
  output logic                            apb_pslverr_o,
  // Clock control
  input  logic                            clk_byp_pad_i,
  output logic                            soc_clk_en_o,
  output logic                            soc_clk_byp_o,
  output logic                            per_clk_en_o,
  output logic                            per_clk_byp_o,
  output logic                            slow_clk_en_o,
  output logic                            slow_clk_byp_o,
  // Peripheral side of the pad mux
  input  logic [`CHIP_PAD_COUNT-1:0]      gpio_out_i,
  input  logic [`CHIP_PAD_COUNT-1:0]      gpio_oe_i,
  output logic [`CHIP_PAD_COUNT-1:0]      gpio_in_o,
  input  logic                            uart_tx_i,
  output logic                            uart_rx_o,
  input  logic [`CHIP_TIMER_CHANNELS-1:0] timer_ch_i,
  // Pad bank
  output logic [`CHIP_PAD_COUNT-1:0]      pad_out_o,
  output logic [`CHIP_PAD_COUNT-1:0]      pad_oe_o,
  input  logic [`CHIP_PAD_COUNT-1:0]      pad_in_i
);

  //////////////////////////////////////////////////
  // Internal buses
  //////////////////////////////////////////////////

  apb_if s_apb_chip_bus ();
  apb_if s_apb_clk_bus ();
  apb_if s_apb_pad_bus ();

  pad_func_e [`CHIP_PAD_COUNT-1:0] s_pad_func;

  // Plain port onto the internal bus
  assign s_apb_chip_bus.psel    = apb_psel_i;
  assign s_apb_chip_bus.penable = apb_penable_i;
  assign s_apb_chip_bus.pwrite  = apb_pwrite_i;
  assign s_apb_chip_bus.paddr   = apb_paddr_i;
  assign s_apb_chip_bus.pwdata  = apb_pwdata_i;
  assign apb_prdata_o           = s_apb_chip_bus.prdata;
  assign apb_pready_o           = s_apb_chip_bus.pready;
  assign apb_pslverr_o          = s_apb_chip_bus.pslverr;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  chip_ctrl_apb_demux i_apb_demux (
    .soc_clk_i ( soc_clk_i      ),
    .rst_n_i   ( rst_n_i        ),
    .slv       ( s_apb_chip_bus ),
    .clk_mst   ( s_apb_clk_bus  ),
    .pad_mst   ( s_apb_pad_bus  )
  );

  clk_ctrl_regs i_clk_ctrl_regs (
    .soc_clk_i      ( soc_clk_i      ),
    .rst_n_i        ( rst_n_i        ),
    .apb            ( s_apb_clk_bus  ),
    .clk_byp_pad_i  ( clk_byp_pad_i  ),
    .soc_clk_en_o   ( soc_clk_en_o   ),
    .soc_clk_byp_o  ( soc_clk_byp_o  ),
    .per_clk_en_o   ( per_clk_en_o   ),
    .per_clk_byp_o  ( per_clk_byp_o  ),
    .slow_clk_en_o  ( slow_clk_en_o  ),
    .slow_clk_byp_o ( slow_clk_byp_o )
  );

  pad_cfg_regs i_pad_cfg_regs (
    .soc_clk_i  ( soc_clk_i     ),
    .rst_n_i    ( rst_n_i       ),
    .apb        ( s_apb_pad_bus ),
    .pad_func_o ( s_pad_func    )
  );

  // Any-to-any routing, purely combinational
  pad_mux i_pad_mux (
    .pad_func_i ( s_pad_func ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .gpio_in_o  ( gpio_in_o  ),
    .uart_tx_i  ( uart_tx_i  ),
    .uart_rx_o  ( uart_rx_o  ),
    .timer_ch_i ( timer_ch_i ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   ),
    .pad_in_i   ( pad_in_i   )
  );

endmodule

// ==== hw/pad_mux.sv ====
`timescale 1ns/1ps
`include "chip_ctrl_cfg.svh"

module pad_mux import chip_ctrl_pkg::*; (
  input  pad_func_e [`CHIP_PAD_COUNT-1:0] pad_func_i,
  // GPIO block
  input  logic [`CHIP_PAD_COUNT-1:0]      gpio_out_i,
  input  logic [`CHIP_PAD_COUNT-1:0]      gpio_oe_i,
  output logic [`CHIP_PAD_COUNT-1:0]      gpio_in_o,
  // UART
  input  logic                            uart_tx_i,
  output logic                            uart_rx_o,
  // Timer channels
  input  logic [`CHIP_TIMER_CHANNELS-1:0] timer_ch_i,
  // Pad bank
  output logic [`CHIP_PAD_COUNT-1:0]      pad_out_o,
  output logic [`CHIP_PAD_COUNT-1:0]      pad_oe_o,
  input  logic [`CHIP_PAD_COUNT-1:0]      pad_in_i
);

  //////////////////////////////////////////////////
  // Outbound routing
  //////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < `CHIP_PAD_COUNT; p++) begin
      // Pad released unless a function drives it
      pad_out_o[p] = 1'b0;
      pad_oe_o[p]  = 1'b0;
      case (pad_func_i[p])
        PAD_FUNC_GPIO: begin
          pad_out_o[p] = gpio_out_i[p];
          pad_oe_o[p]  = gpio_oe_i[p];
        end
        PAD_FUNC_UART_TX: begin
          pad_out_o[p] = uart_tx_i;
          pad_oe_o[p]  = 1'b1;
        end
        PAD_FUNC_TIMER: begin
          // Channels repeat across the bank
          pad_out_o[p] = timer_ch_i[p % `CHIP_TIMER_CHANNELS];
          pad_oe_o[p]  = 1'b1;
        end
        default: begin
          // UART RX, input only
          pad_out_o[p] = 1'b0;
          pad_oe_o[p]  = 1'b0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Inbound routing
  //////////////////////////////////////////////////

  // Lowest RX pad wins, idle line high when none
  always_comb begin
    uart_rx_o = 1'b1;
    for (int p = `CHIP_PAD_COUNT - 1; p >= 0; p--) begin
      if (pad_func_i[p] == PAD_FUNC_UART_RX) begin
        uart_rx_o = pad_in_i[p];
      end
    end
  end

  // GPIO sees every pad whatever its function
  assign gpio_in_o = pad_in_i;

endmodule

// ==== hw/pad_cfg_regs.sv ====
`timescale 1ns/1ps
`include "chip_ctrl_cfg.svh"

module pad_cfg_regs import chip_ctrl_pkg::*; (
  input  logic                                soc_clk_i,
  input  logic                                rst_n_i,
  apb_if.slave                                apb,
  output pad_func_e [`CHIP_PAD_COUNT-1:0]     pad_func_o
);

  pad_func_e [`CHIP_PAD_COUNT-1:0]          pad_func_q;
  logic                                     access;
  // Word index, byte lane bits dropped
  logic [`CHIP_REGION_OFFSET_WIDTH-3:0]     pad_idx;
  logic [$clog2(`CHIP_PAD_COUNT)-1:0]       pad_sel;
  logic                                     idx_ok;

  assign access  = apb.psel & apb.penable;
  assign pad_idx = apb.paddr[`CHIP_REGION_OFFSET_WIDTH-1:2];
  assign pad_sel = pad_idx[$clog2(`CHIP_PAD_COUNT)-1:0];
  // Words past the last pad are errors
  assign idx_ok  = (pad_idx < `CHIP_PAD_COUNT);

  //////////////////////////////////////////////////
  // Function select registers
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      // All pads come up as GPIO
      for (int p = 0; p < `CHIP_PAD_COUNT; p++) begin
        pad_func_q[p] <= PAD_FUNC_GPIO;
      end
    end else if (access && apb.pwrite && idx_ok) begin
      pad_func_q[pad_sel] <= pad_func_e'(apb.pwdata[1:0]);
    end
  end

  //////////////////////////////////////////////////
  // APB response
  //////////////////////////////////////////////////

  // Zero wait states
  assign apb.pready  = access;
  assign apb.pslverr = access & ~idx_ok;

  // Function in bits 1:0, rest zero
  always_comb begin
    if (access && idx_ok) begin
      apb.prdata = apb_data_t'(pad_func_q[pad_sel]);
    end else begin
      apb.prdata = '0;
    end
  end

  // Straight to the pad multiplexer
  assign pad_func_o = pad_func_q;

  // Each stored function stays a known, legal encoding
  for (genvar g = 0; g < `CHIP_PAD_COUNT; g++) begin : g_func_chk
    a_func_legal : assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
      pad_func_q[g] inside {PAD_FUNC_GPIO, PAD_FUNC_UART_TX,
                            PAD_FUNC_UART_RX, PAD_FUNC_TIMER});
  end

endmodule

// ==== hw/clk_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "chip_ctrl_cfg.svh"

module clk_ctrl_regs import chip_ctrl_pkg::*; (
  input  logic soc_clk_i,
  input  logic rst_n_i,
  apb_if.slave apb,
  // Global bypass from the dedicated pad
  input  logic clk_byp_pad_i,
  output logic soc_clk_en_o,
  output logic soc_clk_byp_o,
  output logic per_clk_en_o,
  output logic per_clk_byp_o,
  output logic slow_clk_en_o,
  output logic slow_clk_byp_o
);

  // Enable and bypass bit pairs for the soc, per and slow clocks
  logic [`CHIP_CLK_CFG_WIDTH-1:0] clk_cfg_q;
  logic                           access;
  logic                           offset_ok;
  logic                           wr_hit;

  assign access    = apb.psel & apb.penable;
  // Single register at offset 0
  assign offset_ok = (apb.paddr[`CHIP_REGION_OFFSET_WIDTH-1:0] == '0);
  assign wr_hit    = access & apb.pwrite & offset_ok;

  //////////////////////////////////////////////////
  // Register
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      clk_cfg_q <= `CHIP_CLK_CFG_RESET;
    end else if (wr_hit) begin
      clk_cfg_q <= apb.pwdata[`CHIP_CLK_CFG_WIDTH-1:0];
    end
  end

  // Zero wait states
  assign apb.pready  = access;
  // Other offsets in the region are errors
  assign apb.pslverr = access & ~offset_ok;
  assign apb.prdata  = (access & offset_ok) ? apb_data_t'(clk_cfg_q) : '0;

  //////////////////////////////////////////////////
  // Clock controls
  //////////////////////////////////////////////////

  // SoC clock
  assign soc_clk_en_o   = clk_cfg_q[0];
  assign soc_clk_byp_o  = clk_cfg_q[1] | clk_byp_pad_i;

  // Peripheral clock
  assign per_clk_en_o   = clk_cfg_q[2];
  assign per_clk_byp_o  = clk_cfg_q[3] | clk_byp_pad_i;

  // Slow clock
  assign slow_clk_en_o  = clk_cfg_q[4];
  assign slow_clk_byp_o = clk_cfg_q[5] | clk_byp_pad_i;

endmodule

// ==== hw/chip_ctrl_apb_demux.sv ====
`timescale 1ns/1ps
`include "chip_ctrl_cfg.svh"

module chip_ctrl_apb_demux import chip_ctrl_pkg::*; (
  input  logic  soc_clk_i,
  input  logic  rst_n_i,
  apb_if.slave  slv,
  apb_if.master clk_mst,
  apb_if.master pad_mst
);

  chip_region_e region;
  logic         access;

  // Access phase of the incoming transfer
  assign access = slv.psel & slv.penable;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Compare only the bits above the region offset
  always_comb begin
    if ((slv.paddr >> `CHIP_REGION_OFFSET_WIDTH) ==
        (apb_addr_t'(`CHIP_CLK_REGION_BASE) >> `CHIP_REGION_OFFSET_WIDTH)) begin
      region = REGION_CLK;
    end else if ((slv.paddr >> `CHIP_REGION_OFFSET_WIDTH) ==
                 (apb_addr_t'(`CHIP_PAD_REGION_BASE) >> `CHIP_REGION_OFFSET_WIDTH)) begin
      region = REGION_PAD;
    end else begin
      // Unmapped, answered locally
      region = REGION_ERR;
    end
  end

  //////////////////////////////////////////////////
  // Request routing
  //////////////////////////////////////////////////

  // Select goes to the decoded target only
  assign clk_mst.psel    = slv.psel & (region == REGION_CLK);
  assign pad_mst.psel    = slv.psel & (region == REGION_PAD);

  // Payload is shared, harmless without select
  assign clk_mst.penable = slv.penable;
  assign clk_mst.pwrite  = slv.pwrite;
  assign clk_mst.paddr   = slv.paddr;
  assign clk_mst.pwdata  = slv.pwdata;
  assign pad_mst.penable = slv.penable;
  assign pad_mst.pwrite  = slv.pwrite;
  assign pad_mst.paddr   = slv.paddr;
  assign pad_mst.pwdata  = slv.pwdata;

  //////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////

  always_comb begin
    case (region)
      REGION_CLK: begin
        slv.prdata  = clk_mst.prdata;
        slv.pready  = clk_mst.pready;
        slv.pslverr = clk_mst.pslverr;
      end
      REGION_PAD: begin
        slv.prdata  = pad_mst.prdata;
        slv.pready  = pad_mst.pready;
        slv.pslverr = pad_mst.pslverr;
      end
      default: begin
        // Error response, zero wait states, no data
        slv.prdata  = '0;
        slv.pready  = access;
        slv.pslverr = access;
      end
    endcase
  end

  // Enable never seen without a select
  a_penable_psel : assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    slv.penable |-> slv.psel);

  // Whichever target is hit, it completes in the first access cycle
  a_zero_wait : assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    access |-> slv.pready);

endmodule

// ==== hw/apb_if.sv ====
`timescale 1ns/1ps

interface apb_if import chip_ctrl_pkg::*; ();

  // Request side
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;

  // Response side
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // Requester, drives select and payload
  modport master (
    output psel,
    output penable,
    output pwrite,
    output paddr,
    output pwdata,
    input  prdata,
    input  pready,
    input  pslverr
  );

  // Completer, answers in the access phase
  modport slave (
    input  psel,
    input  penable,
    input  pwrite,
    input  paddr,
    input  pwdata,
    output prdata,
    output pready,
    output pslverr
  );

endinterface

// ==== hw/chip_ctrl_pkg.sv ====
`include "chip_ctrl_cfg.svh"

package chip_ctrl_pkg;

  //////////////////////////////////////////////////
  // APB bus types
  //////////////////////////////////////////////////

  // Byte address inside the chip control space
  typedef logic [`CHIP_APB_ADDR_WIDTH-1:0] apb_addr_t;

  // Data word
  typedef logic [31:0] apb_data_t;

  //////////////////////////////////////////////////
  // Pad and decode encodings
  //////////////////////////////////////////////////

  // Function selected for one pad
  typedef enum logic [1:0] {
    PAD_FUNC_GPIO    = 2'd0,
    PAD_FUNC_UART_TX = 2'd1,
    PAD_FUNC_UART_RX = 2'd2,
    PAD_FUNC_TIMER   = 2'd3
  } pad_func_e;

  // Target picked by the address decoder
  typedef enum logic [1:0] {
    REGION_ERR = 2'd0,
    REGION_CLK = 2'd1,
    REGION_PAD = 2'd2
  } chip_region_e;

endpackage

// ==== hw/chip_ctrl_cfg.svh ====
`ifndef CHIP_CTRL_CFG_SVH
`define CHIP_CTRL_CFG_SVH

// Pad bank size, any function can go to any pad
`define CHIP_PAD_COUNT 8

// Timer channels that can be routed onto pads
`define CHIP_TIMER_CHANNELS 4

// APB byte address width
`define CHIP_APB_ADDR_WIDTH 12

// Region bases, each region spans 2**CHIP_REGION_OFFSET_WIDTH bytes
`define CHIP_CLK_REGION_BASE 12'h000
`define CHIP_PAD_REGION_BASE 12'h100
`define CHIP_REGION_OFFSET_WIDTH 8

// Clock control register, enables on and bypasses off
`define CHIP_CLK_CFG_WIDTH 6
`define CHIP_CLK_CFG_RESET 6'h15

`endif
